//--- rtl/isaPkg.sv
// instruction set package: field widths, opcode and funct codes, instruction fields, instruction kinds
`default_nettype none

package isaPkg;

	localparam int opcodeWidth = 6;
	localparam int functWidth = 6;

	// opcodes of the kept instructions
	localparam logic [opcodeWidth-1:0] opRtype = 6'h00;
	localparam logic [opcodeWidth-1:0] opJ = 6'h02;
	localparam logic [opcodeWidth-1:0] opJal = 6'h03;
	localparam logic [opcodeWidth-1:0] opBeq = 6'h04;
	localparam logic [opcodeWidth-1:0] opBne = 6'h05;
	localparam logic [opcodeWidth-1:0] opBle = 6'h06;
	localparam logic [opcodeWidth-1:0] opBgt = 6'h07;
	localparam logic [opcodeWidth-1:0] opAddi = 6'h08;
	localparam logic [opcodeWidth-1:0] opAddiu = 6'h09;
	localparam logic [opcodeWidth-1:0] opSlti = 6'h0a;
	localparam logic [opcodeWidth-1:0] opLw = 6'h23;
	localparam logic [opcodeWidth-1:0] opSw = 6'h2b;

	// funct codes, only looked at when opcode is R-type
	localparam logic [functWidth-1:0] fnJr = 6'h08;
	localparam logic [functWidth-1:0] fnAdd = 6'h20;
	localparam logic [functWidth-1:0] fnSub = 6'h22;
	localparam logic [functWidth-1:0] fnAnd = 6'h24;
	localparam logic [functWidth-1:0] fnSlt = 6'h2a;

	typedef struct packed {
		logic [opcodeWidth-1:0] opcode; // instr[31:26]
		logic [functWidth-1:0] funct;   // instr[5:0]
	} instrFields;

	typedef enum logic [4:0] {
		kAdd, kSub, kAnd, kSlt,
		kAddi, kAddiu, kSlti,
		kBeq, kBne, kBle, kBgt,
		kJ, kJal, kJr,
		kLw, kSw,
		kInvalid // anything not listed above
	} instrKind;

endpackage

`default_nettype wire

//--- rtl/controlPkg.sv
// control package: ALU flags, datapath select enums, ALU operations, step enum, control word
`default_nettype none

package controlPkg;

	typedef struct packed {
		logic equal;
		logic greater;
		logic overflow; // signed overflow of the last add or sub
	} aluFlags;

	typedef enum logic [2:0] {
		aluResult,      // pc + 4 straight from the ALU
		aluOutReg,      // branch target saved during decode
		jumpTarget,
		registerA,
		exceptionVector
	} pcSource;

	typedef enum logic {pcAddr, aluOutAddr} addrSource;

	typedef enum logic [1:0] {rd, rt, ra} regDest;

	typedef enum logic [1:0] {aluOutData, mdrData, lessThan} writeSource;

	typedef enum logic {pcA, regA} aluSrcA;

	typedef enum logic [1:0] {regB, immediate, four, shiftedOffset} aluSrcB;

	typedef enum logic [2:0] {passA, add, sub, andOp, compare} aluOp;

	typedef enum logic [2:0] {
		waitReq, fetch, decode, exec1, exec2, exec3, ackWait
	} controlStep;

	typedef struct packed {
		logic pcWrite;
		pcSource pcSel;
		logic memWrite;
		addrSource addrSel;
		logic mdrWrite;
		logic irWrite;
		logic regWrite;
		regDest destSel;
		writeSource dataSel;
		logic abLoad;      // load A and B from the register file
		logic aluOutWrite;
		aluSrcA srcA;
		aluSrcB srcB;
		aluOp op;
		logic epcWrite;
	} controlWord;

	// no writes, every select at its first value
	localparam controlWord idleWord = controlWord'(0);

endpackage

`default_nettype wire

//--- rtl/instrDecoder.sv
// instruction decoder: opcode and funct to instruction kind, held from decode to the next fetch
`timescale 1ns/1ns
`default_nettype none

module instrDecoder (
	input wire logic clock,
	input wire logic reset,
	input wire controlPkg::controlStep step,
	input wire isaPkg::instrFields instr,
	output isaPkg::instrKind kind
);

	isaPkg::instrKind decoded;

	always_comb begin
		decoded = isaPkg::kInvalid;
		case (instr.opcode)
			isaPkg::opRtype: begin
				case (instr.funct) // R-type picks by funct
					isaPkg::fnAdd: decoded = isaPkg::kAdd;
					isaPkg::fnSub: decoded = isaPkg::kSub;
					isaPkg::fnAnd: decoded = isaPkg::kAnd;
					isaPkg::fnSlt: decoded = isaPkg::kSlt;
					isaPkg::fnJr: decoded = isaPkg::kJr;
					default: decoded = isaPkg::kInvalid;
				endcase
			end
			isaPkg::opAddi: decoded = isaPkg::kAddi;
			isaPkg::opAddiu: decoded = isaPkg::kAddiu;
			isaPkg::opSlti: decoded = isaPkg::kSlti;
			isaPkg::opBeq: decoded = isaPkg::kBeq;
			isaPkg::opBne: decoded = isaPkg::kBne;
			isaPkg::opBle: decoded = isaPkg::kBle;
			isaPkg::opBgt: decoded = isaPkg::kBgt;
			isaPkg::opJ: decoded = isaPkg::kJ;
			isaPkg::opJal: decoded = isaPkg::kJal;
			isaPkg::opLw: decoded = isaPkg::kLw;
			isaPkg::opSw: decoded = isaPkg::kSw;
			default: decoded = isaPkg::kInvalid;
		endcase
	end

	// instr is stable for the whole handshake, so taking it as fetch ends
	// gives a valid kind from decode onward
	always_ff @(posedge clock) begin
		if (reset) begin
			kind <= isaPkg::kInvalid;
		end else if (step == controlPkg::fetch) begin
			kind <= decoded;
		end
	end

endmodule

`default_nettype wire

//--- rtl/stepSequencer.sv
// step sequencer: req/ack handshake and the step state from fetch to ackWait
`timescale 1ns/1ns
`default_nettype none

module stepSequencer (
	input wire logic clock,
	input wire logic reset,
	input wire logic req,
	input wire logic finish,
	output controlPkg::controlStep step,
	output logic ack
);

	controlPkg::controlStep nextStep;

	always_comb begin
		nextStep = step;
		case (step)
			controlPkg::waitReq: begin
				if (req) begin
					nextStep = controlPkg::fetch;
				end
			end
			controlPkg::fetch: nextStep = controlPkg::decode; // decode never finishes here
			controlPkg::decode: begin
				nextStep = finish ? controlPkg::ackWait : controlPkg::exec1;
			end
			controlPkg::exec1: begin
				nextStep = finish ? controlPkg::ackWait : controlPkg::exec2;
			end
			controlPkg::exec2: begin
				nextStep = finish ? controlPkg::ackWait : controlPkg::exec3;
			end
			controlPkg::exec3: nextStep = controlPkg::ackWait; // longest instruction ends here
			controlPkg::ackWait: begin
				if (!req) begin // source has seen ack
					nextStep = controlPkg::waitReq;
				end
			end
			default: nextStep = controlPkg::waitReq;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			step <= controlPkg::waitReq;
		end else begin
			step <= nextStep;
		end
	end

	// ack straight from the state, so it is high for every ackWait cycle
	// and a held req simply keeps it there
	assign ack = (step == controlPkg::ackWait);

endmodule

`default_nettype wire

//--- rtl/controlWordGen.sv
// control word generator: registered control word per step and kind, combinational finish
`timescale 1ns/1ns
`default_nettype none

module controlWordGen (
	input wire logic clock,
	input wire logic reset,
	input wire isaPkg::instrKind kind,
	input wire controlPkg::controlStep step,
	input wire controlPkg::aluFlags flags,
	output controlPkg::controlWord ctrl,
	output logic finish
);

	// number of execute steps after decode
	function automatic logic [1:0] execSteps(input isaPkg::instrKind k);
		case (k)
			isaPkg::kSlt, isaPkg::kSlti, isaPkg::kJ, isaPkg::kJr: return 2'd1;
			isaPkg::kSw: return 2'd3;
			isaPkg::kInvalid: return 2'd0;
			default: return 2'd2;
		endcase
	endfunction

	controlPkg::controlWord nextWord;
	logic [1:0] lastExec;
	logic branchTaken;
	logic overflowTrap;
	logic isImm;

	assign lastExec = execSteps(kind);
	assign branchTaken = (kind == isaPkg::kBeq && flags.equal) ||
		(kind == isaPkg::kBne && !flags.equal) ||
		(kind == isaPkg::kBgt && flags.greater) ||
		(kind == isaPkg::kBle && !flags.greater);
	assign overflowTrap = flags.overflow &&
		(kind == isaPkg::kAdd || kind == isaPkg::kSub || kind == isaPkg::kAddi);
	assign isImm = (kind == isaPkg::kAddi || kind == isaPkg::kAddiu || kind == isaPkg::kSlti);

	always_comb begin
		case (step)
			controlPkg::decode: finish = (lastExec == 2'd0);
			controlPkg::exec1: finish = (lastExec == 2'd1);
			controlPkg::exec2: finish = (lastExec == 2'd2);
			controlPkg::exec3: finish = (lastExec == 2'd3);
			default: finish = 1'b0;
		endcase
	end

	always_comb begin
		nextWord = controlPkg::idleWord;
		case (step)
			controlPkg::fetch: begin // same for every kind
				nextWord.irWrite = 1'b1;
				nextWord.pcWrite = 1'b1;
				nextWord.pcSel = controlPkg::aluResult;
				nextWord.srcB = controlPkg::four;
				nextWord.op = controlPkg::add;
			end
			controlPkg::decode: begin // read A, B and precompute branch target
				nextWord.abLoad = 1'b1;
				nextWord.aluOutWrite = 1'b1;
				nextWord.srcB = controlPkg::shiftedOffset;
				nextWord.op = controlPkg::add;
			end
			controlPkg::exec1: begin
				nextWord.srcA = controlPkg::regA;
				nextWord.srcB = isImm ? controlPkg::immediate : controlPkg::regB;
				case (kind)
					isaPkg::kAdd, isaPkg::kAddi, isaPkg::kAddiu: begin
						nextWord.op = controlPkg::add;
						nextWord.aluOutWrite = 1'b1;
					end
					isaPkg::kSub: begin
						nextWord.op = controlPkg::sub;
						nextWord.aluOutWrite = 1'b1;
					end
					isaPkg::kAnd: begin
						nextWord.op = controlPkg::andOp;
						nextWord.aluOutWrite = 1'b1;
					end
					isaPkg::kSlt, isaPkg::kSlti: begin // result straight from the compare
						nextWord.op = controlPkg::compare;
						nextWord.regWrite = 1'b1;
						nextWord.dataSel = controlPkg::lessThan;
						nextWord.destSel = isImm ? controlPkg::rt : controlPkg::rd;
					end
					isaPkg::kBeq, isaPkg::kBne, isaPkg::kBle, isaPkg::kBgt: begin
						nextWord.op = controlPkg::compare;
					end
					isaPkg::kJ: begin
						nextWord.pcWrite = 1'b1;
						nextWord.pcSel = controlPkg::jumpTarget;
					end
					isaPkg::kJr: begin
						nextWord.pcWrite = 1'b1;
						nextWord.pcSel = controlPkg::registerA;
					end
					isaPkg::kJal: begin // return address into aluOut
						nextWord.srcA = controlPkg::pcA;
						nextWord.op = controlPkg::passA;
						nextWord.aluOutWrite = 1'b1;
					end
					isaPkg::kLw: begin
						nextWord.srcB = controlPkg::immediate;
						nextWord.op = controlPkg::add;
						nextWord.aluOutWrite = 1'b1;
						nextWord.addrSel = controlPkg::aluOutAddr;
						nextWord.mdrWrite = 1'b1;
					end
					isaPkg::kSw: begin
						nextWord.srcB = controlPkg::immediate;
						nextWord.op = controlPkg::add;
						nextWord.aluOutWrite = 1'b1;
					end
					default: nextWord = controlPkg::idleWord;
				endcase
			end
			controlPkg::exec2: begin
				case (kind)
					isaPkg::kAdd, isaPkg::kSub, isaPkg::kAnd, isaPkg::kAddi, isaPkg::kAddiu: begin
						if (overflowTrap) begin // save pc and go to the handler
							nextWord.epcWrite = 1'b1;
							nextWord.pcWrite = 1'b1;
							nextWord.pcSel = controlPkg::exceptionVector;
						end else begin
							nextWord.regWrite = 1'b1;
							nextWord.dataSel = controlPkg::aluOutData;
							nextWord.destSel = isImm ? controlPkg::rt : controlPkg::rd;
						end
					end
					isaPkg::kBeq, isaPkg::kBne, isaPkg::kBle, isaPkg::kBgt: begin
						nextWord.pcWrite = branchTaken;
						nextWord.pcSel = controlPkg::aluOutReg;
					end
					isaPkg::kJal: begin
						nextWord.regWrite = 1'b1;
						nextWord.destSel = controlPkg::ra;
						nextWord.dataSel = controlPkg::aluOutData;
						nextWord.pcWrite = 1'b1;
						nextWord.pcSel = controlPkg::jumpTarget;
					end
					isaPkg::kLw: begin
						nextWord.regWrite = 1'b1;
						nextWord.destSel = controlPkg::rt;
						nextWord.dataSel = controlPkg::mdrData;
					end
					isaPkg::kSw: nextWord.addrSel = controlPkg::aluOutAddr; // address settles
					default: nextWord = controlPkg::idleWord;
				endcase
			end
			controlPkg::exec3: begin
				if (kind == isaPkg::kSw) begin
					nextWord.addrSel = controlPkg::aluOutAddr;
					nextWord.memWrite = 1'b1;
				end
			end
			default: nextWord = controlPkg::idleWord; // waitReq and ackWait
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			ctrl <= controlPkg::idleWord;
		end else begin
			ctrl <= nextWord; // one cycle behind step
		end
	end

endmodule

`default_nettype wire

//--- rtl/controlUnit.sv
// control unit top: decoder, step sequencer and control word generator
`timescale 1ns/1ns
`default_nettype none

module controlUnit (
	input wire logic clock,
	input wire logic reset,
	input wire logic req,
	input wire isaPkg::instrFields instr,
	input wire controlPkg::aluFlags flags,
	output logic ack,
	output controlPkg::controlWord ctrl
);

	controlPkg::controlStep step;
	isaPkg::instrKind kind;
	logic finish;

	instrDecoder decoder (
		.clock(clock),
		.reset(reset),
		.step(step),
		.instr(instr),
		.kind(kind)
	);

	stepSequencer sequencer (
		.clock(clock),
		.reset(reset),
		.req(req),
		.finish(finish), // length comes from the generator
		.step(step),
		.ack(ack)
	);

	controlWordGen generator (
		.clock(clock),
		.reset(reset),
		.kind(kind),
		.step(step),
		.flags(flags),
		.ctrl(ctrl),
		.finish(finish)
	);

endmodule

`default_nettype wire

//--- testbench/controlUnit_assertions.sv
// concurrent assertions on the control unit handshake and reset state, bound to controlUnit
`timescale 1ns/1ns
`default_nettype none

module controlUnitAssertions (
	input wire logic clock,
	input wire logic reset,
	input wire logic req,
	input wire logic ack,
	input wire controlPkg::controlWord ctrl
);

	logic anyWrite;

	assign anyWrite = ctrl.pcWrite | ctrl.memWrite | ctrl.mdrWrite | ctrl.irWrite |
		ctrl.regWrite | ctrl.abLoad | ctrl.aluOutWrite | ctrl.epcWrite;

	ackNeedsReq: assert property (@(posedge clock) disable iff (reset) $rose(ack) |-> $past(req))
		else $error("ack rose while req was low");

	resetIdle: assert property (@(posedge clock) reset |=> (!ack && !anyWrite))
		else $error("ack or a write enable high after reset");

	ackAfterReqLow: assert property (@(posedge clock) disable iff (reset)
		$fell(ack) |-> !$past(req))
		else $error("ack fell while req was still high");

endmodule

bind controlUnit controlUnitAssertions checks (
	.clock(clock),
	.reset(reset),
	.req(req),
	.ack(ack),
	.ctrl(ctrl)
);

`default_nettype wire

//--- testbench/controlModel.svh
// reference model: instruction encodings, kind lookup, execute step counts, expected control words
`ifndef CONTROL_MODEL_SVH
`define CONTROL_MODEL_SVH

// entry i encodes kind i, funct only matters for R-type
localparam logic [5:0] opTable [16] = '{
	isaPkg::opRtype, isaPkg::opRtype, isaPkg::opRtype, isaPkg::opRtype,
	isaPkg::opAddi, isaPkg::opAddiu, isaPkg::opSlti,
	isaPkg::opBeq, isaPkg::opBne, isaPkg::opBle, isaPkg::opBgt,
	isaPkg::opJ, isaPkg::opJal, isaPkg::opRtype, isaPkg::opLw, isaPkg::opSw
};
localparam logic [5:0] fnTable [16] = '{
	isaPkg::fnAdd, isaPkg::fnSub, isaPkg::fnAnd, isaPkg::fnSlt,
	6'h00, 6'h00, 6'h00, 6'h00, 6'h00, 6'h00, 6'h00, 6'h00, 6'h00,
	isaPkg::fnJr, 6'h00, 6'h00
};

function automatic isaPkg::instrKind modelKind(input isaPkg::instrFields f);
	for (int i = 0; i < 16; i++) begin
		if (f.opcode == opTable[i] && (f.opcode != isaPkg::opRtype || f.funct == fnTable[i])) begin
			return isaPkg::instrKind'(i);
		end
	end
	return isaPkg::kInvalid;
endfunction

function automatic int execCount(input isaPkg::instrKind k);
	case (k)
		isaPkg::kSlt, isaPkg::kSlti, isaPkg::kJ, isaPkg::kJr: return 1;
		isaPkg::kSw: return 3;
		isaPkg::kInvalid: return 0; // ends in decode
		default: return 2;
	endcase
endfunction

// idx 0 is fetch, 1 decode, 2 and up the execute steps
function automatic controlPkg::controlWord expectedWord(input isaPkg::instrKind k, input int idx,
		input controlPkg::aluFlags f);
	controlPkg::controlWord w;
	logic imm;
	logic aluKind;
	logic branch;
	logic taken;
	w = '0; // no writes, first select of every mux
	imm = k inside {isaPkg::kAddi, isaPkg::kAddiu, isaPkg::kSlti};
	aluKind = k inside {isaPkg::kAdd, isaPkg::kSub, isaPkg::kAnd, isaPkg::kAddi, isaPkg::kAddiu};
	branch = k inside {isaPkg::kBeq, isaPkg::kBne, isaPkg::kBle, isaPkg::kBgt};
	taken = (k == isaPkg::kBeq) ? f.equal : (k == isaPkg::kBne) ? !f.equal :
		(k == isaPkg::kBgt) ? f.greater : !f.greater;
	if (idx == 0) begin
		w.irWrite = 1'b1;
		w.pcWrite = 1'b1; // pc + 4 from the ALU
		w.srcB = controlPkg::four;
		w.op = controlPkg::add;
	end else if (idx == 1) begin
		w.abLoad = 1'b1;
		w.aluOutWrite = 1'b1; // branch target
		w.srcB = controlPkg::shiftedOffset;
		w.op = controlPkg::add;
	end else if (idx == 2) begin
		w.srcA = controlPkg::regA;
		w.srcB = imm ? controlPkg::immediate : controlPkg::regB;
		if (aluKind) begin
			w.aluOutWrite = 1'b1;
			w.op = (k == isaPkg::kSub) ? controlPkg::sub :
				(k == isaPkg::kAnd) ? controlPkg::andOp : controlPkg::add;
		end else if (k == isaPkg::kSlt || k == isaPkg::kSlti) begin
			w.op = controlPkg::compare;
			w.regWrite = 1'b1;
			w.dataSel = controlPkg::lessThan;
			w.destSel = imm ? controlPkg::rt : controlPkg::rd;
		end else if (branch) begin
			w.op = controlPkg::compare;
		end else if (k == isaPkg::kJ || k == isaPkg::kJr) begin
			w.pcWrite = 1'b1;
			w.pcSel = (k == isaPkg::kJ) ? controlPkg::jumpTarget : controlPkg::registerA;
		end else if (k == isaPkg::kJal) begin
			w.srcA = controlPkg::pcA; // pc passes to aluOut
			w.aluOutWrite = 1'b1;
		end else begin
			w.srcB = controlPkg::immediate; // lw and sw address
			w.op = controlPkg::add;
			w.aluOutWrite = 1'b1;
			w.mdrWrite = (k == isaPkg::kLw);
			w.addrSel = (k == isaPkg::kLw) ? controlPkg::aluOutAddr : controlPkg::pcAddr;
		end
	end else if (idx == 3) begin
		if (aluKind && f.overflow && k != isaPkg::kAnd && k != isaPkg::kAddiu) begin
			w.epcWrite = 1'b1;
			w.pcWrite = 1'b1;
			w.pcSel = controlPkg::exceptionVector;
		end else if (aluKind) begin
			w.regWrite = 1'b1;
			w.destSel = imm ? controlPkg::rt : controlPkg::rd;
		end else if (branch) begin
			w.pcWrite = taken;
			w.pcSel = controlPkg::aluOutReg;
		end else if (k == isaPkg::kJal) begin
			w.regWrite = 1'b1;
			w.destSel = controlPkg::ra;
			w.pcWrite = 1'b1;
			w.pcSel = controlPkg::jumpTarget;
		end else if (k == isaPkg::kLw) begin
			w.regWrite = 1'b1;
			w.destSel = controlPkg::rt;
			w.dataSel = controlPkg::mdrData;
		end else begin
			w.addrSel = controlPkg::aluOutAddr; // sw address settles
		end
	end else begin
		w.addrSel = controlPkg::aluOutAddr; // only sw gets here
		w.memWrite = 1'b1;
	end
	return w;
endfunction

`endif

//--- testbench/tbControlUnit.sv
// control unit testbench with clock, reset, random instructions, handshake and word checks
`timescale 1ns/1ns
`default_nettype none

module tbControlUnit;

	localparam int numInstr = 300;
	localparam controlPkg::controlWord quietWord = '0; // all enables low and first selects

	logic clock;
	logic reset;
	logic req;
	isaPkg::instrFields instr;
	controlPkg::aluFlags flags;
	logic ack;
	controlPkg::controlWord ctrl;
	int seed;

	`include "controlModel.svh"

	controlUnit dut (
		.clock(clock),
		.reset(reset),
		.req(req),
		.instr(instr),
		.flags(flags),
		.ack(ack),
		.ctrl(ctrl)
	);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	task automatic compare(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		if (actual !== expected) begin
			$display("ERR %0t: %s got %h expected %h", $time, what, actual, expected);
			$display("Errors found");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic timedOut(input string what);
		$display("timed out waiting for %s", what);
		$display("Errors found");
		$fatal(1, "timeout");
	endtask

	// one full four-phase handshake with req held for hold extra cycles
	task automatic runInstr(input isaPkg::instrFields f, input controlPkg::aluFlags fl,
			input int hold);
		isaPkg::instrKind k;
		int words;
		int edges;
		k = modelKind(f);
		words = execCount(k) + 2; // fetch and decode come first
		compare(32'(ack), 32'd0, "ack before req");
		instr = f;
		flags = fl;
		req = 1'b1;
		edges = 0;
		do begin
			@(posedge clock);
			#1;
			edges++;
			if (edges == 1) begin
				compare(32'(ctrl), 32'(quietWord), "word at the edge taking req");
			end else if (edges <= words + 1) begin
				compare(32'(ctrl), 32'(expectedWord(k, edges - 2, fl)),
					$sformatf("%s word %0d", k.name(), edges - 2));
			end
			if (!ack && edges > words + 4) begin
				timedOut("ack to rise");
			end
		end while (!ack);
		compare(edges, words + 1, "edges from req to ack"); // E+3 with the req edge
		repeat (hold) begin
			@(posedge clock);
			#1;
			compare(32'(ack), 32'd1, "ack while req held");
			compare(32'(ctrl), 32'(quietWord), "word while req held");
		end
		req = 1'b0;
		edges = 0;
		do begin
			@(posedge clock);
			#1;
			edges++;
			if (ack && edges > 4) begin
				timedOut("ack to fall");
			end
		end while (ack);
		compare(edges, 1, "edges from req low to ack low");
		compare(32'(ctrl), 32'(quietWord), "word between instructions");
	endtask

	initial begin
		isaPkg::instrFields f;
		controlPkg::aluFlags fl;
		int pick;
		int hold;
		seed = 47;
		reset = 1'b1;
		req = 1'b0;
		instr = '0;
		flags = '0;
		repeat (16) @(posedge clock);
		#1;
		reset = 1'b0;
		repeat (3) begin // idle until the first req
			@(posedge clock);
			#1;
			compare(32'(ack), 32'd0, "ack after reset");
			compare(32'(ctrl), 32'(quietWord), "word after reset");
		end
		for (int n = 0; n < numInstr; n++) begin
			pick = (n < 16) ? n : int'($unsigned($random(seed)) % 20); // every kind once first
			if (pick < 16) begin
				f.opcode = opTable[pick];
				f.funct = (opTable[pick] == isaPkg::opRtype) ? fnTable[pick] : 6'($random(seed));
			end else begin
				f = 12'($random(seed)); // mostly unknown encodings
			end
			fl = 3'($random(seed));
			hold = int'($unsigned($random(seed)) % 4);
			runInstr(f, fl, hold);
		end
		$display("No errors");
		$finish;
	end

endmodule

`default_nettype wire

//--- sources.f
rtl/isaPkg.sv
rtl/controlPkg.sv
rtl/instrDecoder.sv
rtl/stepSequencer.sv
rtl/controlWordGen.sv
rtl/controlUnit.sv
testbench/controlUnit_assertions.sv
testbench/tbControlUnit.sv
+incdir+testbench

//--- run.sh
#!/bin/sh
# build the control unit testbench with Verilator, run it, then look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tbControlUnit -f sources.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

output=$(./obj_dir/VtbControlUnit)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "No errors"; then
	exit 0
fi
echo "simulation did not report a clean run"
exit 1
